// File: flist.f
rtl/slam_pkg.sv
rtl/stage_decode.sv
rtl/cordic_rotate.sv
rtl/nonlinear_execute.sv
rtl/state_writeback.sv
rtl/slam_top.sv
tests/tb_slam_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build tb_slam_top with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module tb_slam_top -f flist.f -o Vtb_slam_top
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_slam_top > "$log" 2>&1
run_status=$?

if grep -q "TESTS FAILED" "$log"; then
  echo "simulation reported a failure, see $log"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status, see $log"
  exit 1
fi
if ! grep -q "TESTS PASSED" "$log"; then
  echo "simulation ended without a result line, see $log"
  exit 1
fi
echo "simulation passed, log in $log"
exit 0

// File: tests/slam_vectors.hex
// one command per line: stage vlr alpha rk phi nwrites, then addr data for up to three writes
// stage 1 prediction, 2 new landmark, 3 and 4 reserved; unused addr data pairs are zero
1 00000010 00020000 00000000 00000000 3 00 0000000e 01 00000001 02 00020000
3 00000010 00020000 00000010 00040000 0 00 00000000 00 00000000 00 00000000
1 00000010 000c0000 00000000 00000000 3 00 0000001b 01 00000008 02 fff4de00
1 00000010 fffc0000 00000000 00000000 3 00 0000000d 01 00000002 02 000a0000
2 00000000 00000000 00000010 00000000 2 03 00000002 04 0000000c 00 00000000
2 00000000 00000000 00000010 fff80000 2 05 0000001a 06 00000009 00 00000000
2 00000000 00000000 00000010 00040000 2 07 ffffffff 08 fffffffc 00 00000000
4 00000000 00000000 00000010 00000000 0 00 00000000 00 00000000 00 00000000
2 00000000 00000000 00000000 00000000 2 09 0000000d 0a 00000002 00 00000000
2 00000010 00000000 00000000 00080000 2 0b 0000000d 0c 00000002 00 00000000
2 00000000 00040000 00000000 fff00000 2 0d 0000000d 0e 00000002 00 00000000
2 00000000 00000000 00000000 00040000 2 0f 0000000d 10 00000002 00 00000000
2 00000010 00000000 00000000 00000000 2 11 0000000d 12 00000002 00 00000000
2 00000000 00000000 00000000 fffc0000 2 13 0000000d 14 00000002 00 00000000
2 00000000 000c0000 00000000 00000000 2 15 0000000d 16 00000002 00 00000000
2 00000000 00000000 00000000 000c0000 2 17 0000000d 18 00000002 00 00000000
2 00000000 00000000 00000000 00000000 2 19 0000000d 1a 00000002 00 00000000
2 00000010 00000000 00000000 fff80000 2 1b 0000000d 1c 00000002 00 00000000
2 00000000 00000000 00000000 00000000 2 1d 0000000d 1e 00000002 00 00000000
2 00000000 00000000 00000000 00020000 2 1f 0000000d 20 00000002 00 00000000
2 00000000 00000000 00000000 00000000 2 21 0000000d 22 00000002 00 00000000
2 00000000 00000000 00000010 00000000 0 00 00000000 00 00000000 00 00000000
1 00000010 00000000 00000000 00000000 3 00 00000002 01 0000000c 02 000a0000

// File: tests/tb_slam_top.sv
`timescale 1ns/1ps

module tb_slam_top;
  import slam_pkg::*;

  localparam int NREC    = 23;
  localparam int REC_W   = 12;
  localparam int TIMEOUT = 200;
  // cycles a command stays on stage_val after ready returns
  localparam int HOLD    = 4;

  logic                 clk;
  logic                 sys_rst;
  stage_e               stage_val;
  logic signed [DW-1:0] vlr;
  logic signed [DW-1:0] alpha;
  logic signed [DW-1:0] rk;
  logic signed [DW-1:0] phi;
  logic                 stage_rdy;
  logic                 plb_en;
  logic                 plb_we;
  logic [MEM_AW-1:0]    plb_addr;
  logic [DW-1:0]        plb_din;

  logic [31:0] vec_mem [NREC*REC_W];
  plb_req_t    plb_seen;
  plb_req_t    wr_q [$];
  logic [15:0] lfsr;

  slam_top dut0 (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .stage_val (stage_val),
    .vlr       (vlr),
    .alpha     (alpha),
    .rk        (rk),
    .phi       (phi),
    .stage_rdy (stage_rdy),
    .plb_en    (plb_en),
    .plb_we    (plb_we),
    .plb_addr  (plb_addr),
    .plb_din   (plb_din)
  );

  // 10 ns clock
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  assign plb_seen = '{en: plb_en, we: plb_we, addr: plb_addr, din: plb_din};

  // write monitor sampled mid-cycle on either strobe
  always @(negedge clk) begin
    if (!sys_rst && (plb_en || plb_we)) begin
      wr_q.push_back(plb_seen);
    end
  end

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_plb(input plb_req_t want, input plb_req_t got, input int idx);
    if (got.en !== want.en) begin
      $display("[ERROR] plb_en write %0d: expected 0x%h, got 0x%h", idx, want.en, got.en);
      abort_run();
    end
    if (got.we !== want.we) begin
      $display("[ERROR] plb_we write %0d: expected 0x%h, got 0x%h", idx, want.we, got.we);
      abort_run();
    end
    if (got.addr !== want.addr) begin
      $display("[ERROR] plb_addr write %0d: expected 0x%h, got 0x%h",
               idx, want.addr, got.addr);
      abort_run();
    end
    if (got.din !== want.din) begin
      $display("[ERROR] plb_din write %0d: expected 0x%h, got 0x%h", idx, want.din, got.din);
      abort_run();
    end
  endtask

  task automatic check_rdy(input bit want, input bit got);
    if (got !== want) begin
      $display("[ERROR] stage_rdy: expected 0x%h, got 0x%h", want, got);
      abort_run();
    end
  endtask

  task automatic check_count(input int want, input int got);
    if (got !== want) begin
      $display("[ERROR] plb write count: expected 0x%h, got 0x%h", want, got);
      abort_run();
    end
  endtask

  // bounded wait for a stage_rdy level
  task automatic wait_rdy(input bit level);
    int n;
    n = 0;
    @(negedge clk);
    while (stage_rdy !== level && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (stage_rdy !== level) begin
      $display("stage_rdy did not reach %0d within %0d cycles", level, TIMEOUT);
      abort_run();
    end
  endtask

  // 16-bit galois lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hB400;
    end
    return n;
  endfunction

  // three lfsr bits with one step per bit
  task automatic pick_gap(output int gap);
    gap = 0;
    for (int b = 0; b < 3; b++) begin
      gap = (gap << 1) | int'(lfsr[0]);
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // apply one vector line and compare its writes
  task automatic run_record(input int r);
    int       base;
    int       nw;
    stage_e   st;
    plb_req_t want;
    base = r * REC_W;
    st   = stage_e'(vec_mem[base][2:0]);
    nw   = int'(vec_mem[base + 5]);
    @(posedge clk);
    #1;
    stage_val = st;
    vlr       = vec_mem[base + 1];
    alpha     = vec_mem[base + 2];
    rk        = vec_mem[base + 3];
    phi       = vec_mem[base + 4];
    // real commands take ready low and then back high
    if (st == STAGE_PRD || st == STAGE_NEW) begin
      wait_rdy(1'b0);
      wait_rdy(1'b1);
    end
    // engine stays idle on a held or reserved code
    repeat (HOLD) begin
      @(negedge clk);
      check_rdy(1'b1, stage_rdy);
    end
    @(posedge clk);
    #1;
    stage_val = STAGE_IDLE;
    check_count(nw, wr_q.size());
    for (int i = 0; i < nw; i++) begin
      want = '{en: 1'b1,
               we: 1'b1,
               addr: vec_mem[base + 6 + 2 * i][MEM_AW-1:0],
               din: vec_mem[base + 7 + 2 * i]};
      check_plb(want, wr_q[i], i);
    end
    wr_q.delete();
  endtask

  initial begin
    int gap;
    sys_rst   = 1'b1;
    stage_val = STAGE_IDLE;
    vlr       = '0;
    alpha     = '0;
    rk        = '0;
    phi       = '0;
    lfsr      = 16'd17702;
    gap       = 0;
    $readmemh("tests/slam_vectors.hex", vec_mem);
    if ($isunknown(vec_mem[0]) || vec_mem[0] == '0) begin
      $display("vector file tests/slam_vectors.hex is empty or did not load");
      abort_run();
    end
    repeat (10) @(posedge clk);
    #1;
    sys_rst = 1'b0;
    // idle host after reset keeps ready high and the port quiet
    repeat (8) begin
      @(negedge clk);
      check_rdy(1'b1, stage_rdy);
    end
    @(posedge clk);
    #1;
    check_count(0, wr_q.size());
    for (int r = 0; r < NREC; r++) begin
      run_record(r);
      pick_gap(gap);
      repeat (gap) @(posedge clk);
    end
    // nothing trails the last command
    repeat (4) @(posedge clk);
    #1;
    check_count(0, wr_q.size());
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: rtl/slam_top.sv
`timescale 1ns/1ps

module slam_top (
  input  logic                            clk,
  input  logic                            sys_rst,
  input  slam_pkg::stage_e                stage_val,
  input  logic signed [slam_pkg::DW-1:0]  vlr,
  input  logic signed [slam_pkg::DW-1:0]  alpha,
  input  logic signed [slam_pkg::DW-1:0]  rk,
  input  logic signed [slam_pkg::DW-1:0]  phi,
  output logic                            stage_rdy,
  output logic                            plb_en,
  output logic                            plb_we,
  output logic [slam_pkg::MEM_AW-1:0]     plb_addr,
  output logic [slam_pkg::DW-1:0]         plb_din
);
  import slam_pkg::*;

  logic     op_valid;
  op_t      op;
  logic     res_valid;
  result_t  res;
  logic     lm_full;
  plb_req_t plb;

  // host command edge and operand capture
  stage_decode u_decode (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .stage_val (stage_val),
    .vlr       (vlr),
    .alpha     (alpha),
    .rk        (rk),
    .phi       (phi),
    .busy      (!stage_rdy),
    .op_valid  (op_valid),
    .op        (op)
  );

  nonlinear_execute u_execute (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .op_valid  (op_valid),
    .op        (op),
    .lm_full   (lm_full),
    .res_valid (res_valid),
    .res       (res)
  );

  // memory writes and the host ready
  state_writeback u_writeback (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .op_valid  (op_valid),
    .res_valid (res_valid),
    .res       (res),
    .plb       (plb),
    .stage_rdy (stage_rdy),
    .lm_full   (lm_full)
  );

  assign plb_en   = plb.en;
  assign plb_we   = plb.we;
  assign plb_addr = plb.addr;
  assign plb_din  = plb.din;

endmodule

// File: rtl/state_writeback.sv
`timescale 1ns/1ps

module state_writeback (
  input  logic               clk,
  input  logic               sys_rst,
  input  logic               op_valid,
  input  logic               res_valid,
  input  slam_pkg::result_t  res,
  output slam_pkg::plb_req_t plb,
  output logic               stage_rdy,
  output logic               lm_full
);
  import slam_pkg::*;

  logic              wr_en;
  logic [MEM_AW-1:0] wr_addr;
  coord_t            wr_din;
  coord_t            pend0;
  coord_t            pend1;
  logic [1:0]        left;
  logic              rdy_r;
  logic [LM_CW-1:0]  lm_cnt;
  logic [MEM_AW-1:0] base;

  assign lm_full = (lm_cnt == LM_CW'(LM_MAX));
  // next free landmark slot, or the pose words
  assign base = (res.stage == STAGE_NEW) ? MEM_AW'(LM_BASE + 2 * lm_cnt)
                                         : MEM_AW'(POSE_BASE);

  // drops in the issue cycle, back up after the last write
  assign stage_rdy = rdy_r && !op_valid;
  assign plb       = '{en: wr_en, we: wr_en, addr: wr_addr, din: wr_din};

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      wr_en  <= 1'b0;
      left   <= '0;
      rdy_r  <= 1'b1;
      lm_cnt <= '0;
    end else begin
      if (op_valid) begin
        rdy_r <= 1'b0;
      end
      if (res_valid) begin
        if (res.nwords == 2'd0) begin
          // dropped landmark, nothing to write
          wr_en <= 1'b0;
          rdy_r <= 1'b1;
        end else begin
          wr_en <= 1'b1;
          left  <= res.nwords - 2'd1;
        end
        if (res.stage == STAGE_NEW && res.nwords != 2'd0) begin
          lm_cnt <= lm_cnt + 1'b1;
        end
      end else if (left != 2'd0) begin
        wr_en <= 1'b1;
        left  <= left - 2'd1;
      end else if (wr_en) begin
        wr_en <= 1'b0;
        rdy_r <= 1'b1;
      end
    end
  end

  // words shift out one per cycle
  always_ff @(posedge clk) begin
    if (res_valid) begin
      wr_addr <= base;
      wr_din  <= res.w0;
      pend0   <= res.w1;
      pend1   <= res.w2;
    end else if (left != 2'd0) begin
      wr_addr <= wr_addr + 1'b1;
      wr_din  <= pend0;
      pend0   <= pend1;
    end
  end

  a_write_busy: assert property (@(posedge clk) disable iff (sys_rst)
    plb.we |-> plb.en && !stage_rdy);

  // landmark area ends at LM_BASE + 2*LM_MAX
  a_addr_range: assert property (@(posedge clk) disable iff (sys_rst)
    plb.en |-> plb.addr < MEM_AW'(LM_BASE + 2 * LM_MAX));

endmodule

// File: rtl/nonlinear_execute.sv
`timescale 1ns/1ps

module nonlinear_execute (
  input  logic              clk,
  input  logic              sys_rst,
  input  logic              op_valid,
  input  slam_pkg::op_t     op,
  input  logic              lm_full,
  output logic              res_valid,
  output slam_pkg::result_t res
);
  import slam_pkg::*;

  localparam logic signed [AW:0] TWO_PI = 2 * PI_A;

  typedef enum logic [1:0] {
    EX_IDLE,
    EX_SUM,
    EX_ROT
  } ex_state_e;

  ex_state_e state;
  pose_t     pose;
  op_t       op_r;
  angle_t    rot_angle;
  logic      rot_start;
  logic      rot_done;
  coord_t    rot_x;
  coord_t    rot_y;
  coord_t    sum_x;
  coord_t    sum_y;
  angle_t    theta_next;
  logic      issue;
  logic      drop;
  logic      finish;

  // sum of two angles folded back into +-pi
  function automatic angle_t wrap_sum(angle_t a, angle_t b);
    logic signed [AW:0] s;
    s = {a[AW-1], a} + {b[AW-1], b};
    if (s > PI_A) begin
      s = s - TWO_PI;
    end else if (s < -PI_A) begin
      s = s + TWO_PI;
    end
    return angle_t'(s);
  endfunction

  assign issue      = (state == EX_IDLE) && op_valid;
  // map full, report nothing
  assign drop       = issue && (op.stage == STAGE_NEW) && lm_full;
  assign finish     = (state == EX_ROT) && rot_done;
  assign sum_x      = pose.x + rot_x;
  assign sum_y      = pose.y + rot_y;
  assign theta_next = wrap_sum(pose.theta, op_r.alpha);

  cordic_rotate u_cordic (
    .clk     (clk),
    .sys_rst (sys_rst),
    .start   (rot_start),
    .x_in    ((op_r.stage == STAGE_PRD) ? op_r.vlr : op_r.rk),
    .angle   (rot_angle),
    .done    (rot_done),
    .x_out   (rot_x),
    .y_out   (rot_y)
  );

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state     <= EX_IDLE;
      rot_start <= 1'b0;
      res_valid <= 1'b0;
      pose      <= '0;
    end else begin
      rot_start <= 1'b0;
      res_valid <= 1'b0;
      case (state)
        EX_IDLE: begin
          if (drop) begin
            res_valid <= 1'b1;
          end else if (issue && op.stage == STAGE_PRD) begin
            // rotate by current heading straight away
            rot_start <= 1'b1;
            state     <= EX_ROT;
          end else if (issue && op.stage == STAGE_NEW) begin
            state <= EX_SUM;
          end
        end
        EX_SUM: begin
          rot_start <= 1'b1;
          state     <= EX_ROT;
        end
        EX_ROT: begin
          if (rot_done) begin
            res_valid <= 1'b1;
            state     <= EX_IDLE;
            if (op_r.stage == STAGE_PRD) begin
              pose <= '{x: sum_x, y: sum_y, theta: theta_next};
            end
          end
        end
        default: state <= EX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      op_r      <= op;
      rot_angle <= pose.theta;
    end
    // landmark bearing is heading plus phi
    if (state == EX_SUM) begin
      rot_angle <= wrap_sum(pose.theta, op_r.phi);
    end
    if (drop) begin
      res <= '{stage: STAGE_NEW, nwords: 2'd0, w0: '0, w1: '0, w2: '0};
    end else if (finish) begin
      res.stage <= op_r.stage;
      res.w0    <= sum_x;
      res.w1    <= sum_y;
      if (op_r.stage == STAGE_PRD) begin
        res.nwords <= 2'd3;
        res.w2     <= angle_to_word(theta_next);
      end else begin
        res.nwords <= 2'd2;
        res.w2     <= '0;
      end
    end
  end

endmodule

// File: rtl/cordic_rotate.sv
`timescale 1ns/1ps

module cordic_rotate (
  input  logic             clk,
  input  logic             sys_rst,
  input  logic             start,
  input  slam_pkg::coord_t x_in,
  input  slam_pkg::angle_t angle,
  output logic             done,
  output slam_pkg::coord_t x_out,
  output slam_pkg::coord_t y_out
);
  import slam_pkg::*;

  // atan(2^-i) in angle_t units
  localparam angle_t ATAN_TAB [ITER] = '{
    17'sd12868, 17'sd7596, 17'sd4014, 17'sd2037,
    17'sd1023,  17'sd512,  17'sd256,  17'sd128,
    17'sd64,    17'sd32,   17'sd16,   17'sd8,
    17'sd4,     17'sd2,    17'sd1,    17'sd1
  };
  localparam int CW = $clog2(ITER);

  logic                     busy;
  logic                     last_q;
  logic [CW-1:0]            iter_cnt;
  coord_t                   xr;
  coord_t                   yr;
  angle_t                   zr;
  logic signed [DW+17:0]    scaled;
  coord_t                   x_s;
  coord_t                   x0;
  coord_t                   y0;
  angle_t                   z0;
  coord_t                   x_sh;
  coord_t                   y_sh;

  // gain removed up front, then quadrant fold by pi/2
  always_comb begin
    scaled = x_in * CORDIC_INV_GAIN;
    x_s    = coord_t'(scaled >>> GAIN_FRAC);
    if (angle > HALF_PI_A) begin
      x0 = '0;
      y0 = x_s;
      z0 = angle - HALF_PI_A;
    end else if (angle < -HALF_PI_A) begin
      x0 = '0;
      y0 = -x_s;
      z0 = angle + HALF_PI_A;
    end else begin
      x0 = x_s;
      y0 = '0;
      z0 = angle;
    end
  end

  assign x_sh = xr >>> iter_cnt;
  assign y_sh = yr >>> iter_cnt;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      busy     <= 1'b0;
      last_q   <= 1'b0;
      done     <= 1'b0;
      iter_cnt <= '0;
    end else begin
      last_q <= 1'b0;
      done   <= last_q;
      if (start) begin
        busy     <= 1'b1;
        iter_cnt <= '0;
      end else if (busy) begin
        iter_cnt <= iter_cnt + 1'b1;
        if (iter_cnt == CW'(ITER - 1)) begin
          busy   <= 1'b0;
          last_q <= 1'b1;
        end
      end
    end
  end

  // micro-rotations, direction from sign of residual angle
  always_ff @(posedge clk) begin
    if (start) begin
      xr <= x0;
      yr <= y0;
      zr <= z0;
    end else if (busy) begin
      if (zr >= 0) begin
        xr <= xr - y_sh;
        yr <= yr + x_sh;
        zr <= zr - ATAN_TAB[iter_cnt];
      end else begin
        xr <= xr + y_sh;
        yr <= yr - x_sh;
        zr <= zr + ATAN_TAB[iter_cnt];
      end
    end
    if (last_q) begin
      x_out <= xr;
      y_out <= yr;
    end
  end

  // sequencer upstream must wait for done
  a_start_idle: assert property (@(posedge clk) disable iff (sys_rst)
    start |-> !busy && !last_q);

endmodule

// File: rtl/stage_decode.sv
`timescale 1ns/1ps

module stage_decode (
  input  logic                            clk,
  input  logic                            sys_rst,
  input  slam_pkg::stage_e                stage_val,
  input  logic signed [slam_pkg::DW-1:0]  vlr,
  input  logic signed [slam_pkg::DW-1:0]  alpha,
  input  logic signed [slam_pkg::DW-1:0]  rk,
  input  logic signed [slam_pkg::DW-1:0]  phi,
  input  logic                            busy,
  output logic                            op_valid,
  output slam_pkg::op_t                   op
);
  import slam_pkg::*;

  stage_e stage_q;
  logic   cmd_now;
  logic   cmd_prev;
  logic   accept;

  // only prediction and new landmark start work
  function automatic logic is_cmd(stage_e s);
    case (s)
      STAGE_PRD, STAGE_NEW: return 1'b1;
      // reserved, behave like idle
      STAGE_UPD, STAGE_ASSOC: return 1'b0;
      default: return 1'b0;
    endcase
  endfunction

  assign cmd_now  = is_cmd(stage_val);
  assign cmd_prev = is_cmd(stage_q);
  // idle to command edge, ignored while an operation runs
  assign accept   = cmd_now && !cmd_prev && !busy;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      stage_q  <= STAGE_IDLE;
      op_valid <= 1'b0;
    end else begin
      stage_q  <= stage_val;
      op_valid <= accept;
    end
  end

  // operands sampled in the accept cycle
  always_ff @(posedge clk) begin
    if (accept) begin
      op <= '{stage: stage_val,
              vlr:   vlr,
              alpha: word_to_angle(alpha),
              rk:    rk,
              phi:   word_to_angle(phi)};
    end
  end

  // issue only from idle, and writeback must hold the engine busy after it
  a_issue_when_idle: assert property (@(posedge clk) disable iff (sys_rst)
    op_valid |-> !$past(busy) ##1 busy);

endmodule

// File: rtl/slam_pkg.sv
package slam_pkg;

  // datapath widths
  localparam int DW = 32;
  localparam int AW = 17;
  // angle words drop their low bits, angle_t is radians with 14 fraction bits
  localparam int ANG_LSB = 4;

  // cordic sizing
  localparam int ITER = 16;
  // 1/K for 16 iterations, Q1.16
  localparam logic signed [17:0] CORDIC_INV_GAIN = 18'sd39797;
  localparam int GAIN_FRAC = 16;

  typedef logic signed [DW-1:0] coord_t;
  typedef logic signed [AW-1:0] angle_t;

  localparam angle_t PI_A = 17'sd51472;
  localparam angle_t HALF_PI_A = 17'sd25736;

  // state memory map
  localparam int POSE_BASE = 0;
  localparam int LM_BASE = 3;
  localparam int LM_MAX = 16;
  localparam int MEM_AW = 6;
  localparam int LM_CW = $clog2(LM_MAX + 1);

  typedef enum logic [2:0] {
    STAGE_IDLE  = 3'b000,
    STAGE_PRD   = 3'b001,
    STAGE_NEW   = 3'b010,
    STAGE_UPD   = 3'b011,
    STAGE_ASSOC = 3'b100
  } stage_e;

  typedef struct packed {
    stage_e stage;
    coord_t vlr;
    angle_t alpha;
    coord_t rk;
    angle_t phi;
  } op_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
    angle_t theta;
  } pose_t;

  typedef struct packed {
    stage_e stage;
    logic [1:0] nwords;
    coord_t w0;
    coord_t w1;
    coord_t w2;
  } result_t;

  typedef struct packed {
    logic en;
    logic we;
    logic [MEM_AW-1:0] addr;
    logic [DW-1:0] din;
  } plb_req_t;

  // sign bit plus bits 19:4 of a host angle word
  function automatic angle_t word_to_angle(logic signed [DW-1:0] w);
    return angle_t'({w[DW-1], w[ANG_LSB +: AW-1]});
  endfunction

  // back to a host angle word, sign extended
  function automatic coord_t angle_to_word(angle_t a);
    coord_t w;
    w = coord_t'(a);
    return w <<< ANG_LSB;
  endfunction

endpackage
